/* verilog/soc_macros.svh */
/*
 * Memory map, RAM size, GPIO widths and CSR bank constants
 * Include in every module that decodes addresses or sizes its ports
 */
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// ------------------------------
// Memory map on address bits 31:29
// ------------------------------
`define SOC_REGION_BRAM 3'b001
`define SOC_REGION_CSR 3'b100

// Word address bits of the on-chip RAM, 1024 words
`define SOC_BRAM_ADR_WIDTH 10

// GPIO pin counts
`define SOC_GPIO_IN_W 3
`define SOC_GPIO_OUT_W 4

// System controller
`define SOC_SYSCTL_BANK 4'h1
`define SOC_SYSTEM_ID 32'h53334145

`endif

/* verilog/soc_pkg.sv */
/*
 * Shared bus and CSR types for the system core
 * Referenced by scoped name from every RTL module
 */
`default_nettype none

package soc_pkg;

	// Plain vectors with a meaning
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0] sel_t;
	// Bank in bits 13:10, register in bits 9:0
	typedef logic [13:0] csr_addr_t;

	// ------------------------------
	// Wishbone classic, single cycle only
	// ------------------------------
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		addr_t adr;
		sel_t sel;
		word_t dat;
	} bus_req_t;

	typedef struct packed {
		logic ack;
		word_t dat;
	} bus_rsp_t;

	// CSR side of the bridge
	typedef struct packed {
		csr_addr_t a;
		logic we;
		word_t dw;
	} csr_req_t;

	// Arbiter owner
	typedef enum logic [1:0] {GRANT_NONE, GRANT_IBUS, GRANT_DBUS} grant_t;

	// Bridge sequencing
	typedef enum logic [1:0] {IDLE, ACCESS, DONE} csrbrg_state_t;

endpackage

`default_nettype wire

/* verilog/bus_arbiter.sv */
/*
 * Two-master shared bus with address decode
 * Data port wins over instruction port when both ask while idle
 * Unmapped regions get an ack with zero data from the arbiter itself
 */
`timescale 1ns/100ps
`default_nettype none
`include "soc_macros.svh"

module bus_arbiter (
	input logic sys_clk,
	input logic rst1,
	input soc_pkg::bus_req_t ibus_req_i,
	input soc_pkg::bus_req_t dbus_req_i,
	output soc_pkg::bus_rsp_t ibus_rsp_o,
	output soc_pkg::bus_rsp_t dbus_rsp_o,
	output soc_pkg::bus_req_t bram_req_o,
	output soc_pkg::bus_req_t csr_req_o,
	input soc_pkg::bus_rsp_t bram_rsp_i,
	input soc_pkg::bus_rsp_t csr_rsp_i
);

	soc_pkg::grant_t grant;
	soc_pkg::bus_req_t owner_req;
	soc_pkg::bus_rsp_t owner_rsp;
	logic [2:0] region;
	logic hit_bram;
	logic hit_csr;
	logic hit_none;
	logic none_ack;

	// ------------------------------
	// Grant FSM
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			grant <= soc_pkg::GRANT_NONE;
		end else begin
			case (grant)
				soc_pkg::GRANT_NONE: begin
					// Data port has priority
					if (dbus_req_i.cyc)
						grant <= soc_pkg::GRANT_DBUS;
					else if (ibus_req_i.cyc)
						grant <= soc_pkg::GRANT_IBUS;
				end
				// Held until the owner releases cyc
				soc_pkg::GRANT_DBUS: begin
					if (!dbus_req_i.cyc)
						grant <= soc_pkg::GRANT_NONE;
				end
				soc_pkg::GRANT_IBUS: begin
					if (!ibus_req_i.cyc)
						grant <= soc_pkg::GRANT_NONE;
				end
				default: grant <= soc_pkg::GRANT_NONE;
			endcase
		end
	end

	// Request of the current owner, all zero when nobody owns the bus
	always_comb begin
		case (grant)
			soc_pkg::GRANT_DBUS: owner_req = dbus_req_i;
			soc_pkg::GRANT_IBUS: owner_req = ibus_req_i;
			default: owner_req = '0;
		endcase
	end

	// ------------------------------
	// Address decode
	// ------------------------------
	assign region = owner_req.adr[31:29];
	assign hit_bram = (region == `SOC_REGION_BRAM);
	assign hit_csr = (region == `SOC_REGION_CSR);
	assign hit_none = !hit_bram && !hit_csr;

	// Slave requests, cyc and stb only reach the decoded slave
	always_comb begin
		bram_req_o = owner_req;
		bram_req_o.cyc = owner_req.cyc & hit_bram;
		bram_req_o.stb = owner_req.stb & hit_bram;
		csr_req_o = owner_req;
		csr_req_o.cyc = owner_req.cyc & hit_csr;
		csr_req_o.stb = owner_req.stb & hit_csr;
	end

	// Unmapped access, one-cycle ack after the grant
	always_ff @(posedge sys_clk) begin
		if (rst1)
			none_ack <= 1'b0;
		else
			none_ack <= owner_req.cyc & owner_req.stb & hit_none & ~none_ack;
	end

	// Response from whichever slave was selected
	always_comb begin
		if (hit_bram) begin
			owner_rsp = bram_rsp_i;
		end else if (hit_csr) begin
			owner_rsp = csr_rsp_i;
		end else begin
			owner_rsp.ack = none_ack;
			owner_rsp.dat = '0;
		end
	end

	// Losing master sees no ack
	assign dbus_rsp_o = (grant == soc_pkg::GRANT_DBUS) ? owner_rsp : '0;
	assign ibus_rsp_o = (grant == soc_pkg::GRANT_IBUS) ? owner_rsp : '0;

endmodule

`default_nettype wire

/* verilog/bram.sv */
/*
 * On-chip RAM slave, one word wide, byte-lane writes
 * Registered read data, ack one cycle after stb
 */
`timescale 1ns/100ps
`default_nettype none
`include "soc_macros.svh"

module bram (
	input logic sys_clk,
	input logic rst1,
	input soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o
);

	soc_pkg::word_t mem [0:(1 << `SOC_BRAM_ADR_WIDTH) - 1];
	soc_pkg::word_t rdata;
	logic [`SOC_BRAM_ADR_WIDTH-1:0] word_adr;
	logic access;
	logic ack;

	// Word index from byte address, bits 11:2
	assign word_adr = req_i.adr[`SOC_BRAM_ADR_WIDTH+1:2];

	// New cycle only while ack is low
	assign access = req_i.cyc & req_i.stb & ~ack;

	// Lane-merged write
	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < 4; i++) begin
			if (access && req_i.we && req_i.sel[i])
				mem[word_adr][8*i +: 8] <= req_i.dat[8*i +: 8];
		end
	end

	// Read port, old data on a write cycle
	always_ff @(posedge sys_clk) begin
		rdata <= mem[word_adr];
	end

	// Single-cycle ack
	always_ff @(posedge sys_clk) begin
		if (rst1)
			ack <= 1'b0;
		else
			ack <= access;
	end

	assign rsp_o = '{ack: ack, dat: rdata};

endmodule

`default_nettype wire

/* verilog/csr_bridge.sv */
/*
 * Wishbone to CSR bridge
 * One stb becomes one CSR access, ack two cycles later
 */
`timescale 1ns/100ps
`default_nettype none

module csr_bridge (
	input logic sys_clk,
	input logic rst1,
	input soc_pkg::bus_req_t bus_req_i,
	output soc_pkg::bus_rsp_t bus_rsp_o,
	output soc_pkg::csr_req_t csr_o,
	input soc_pkg::word_t csr_rdata_i
);

	soc_pkg::csrbrg_state_t state;
	soc_pkg::csr_addr_t csr_a;
	soc_pkg::word_t csr_dw;
	soc_pkg::word_t rdata;
	logic csr_we;

	// ------------------------------
	// Access sequencing
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			state <= soc_pkg::IDLE;
			csr_we <= 1'b0;
		end else begin
			case (state)
				soc_pkg::IDLE: begin
					if (bus_req_i.cyc && bus_req_i.stb) begin
						state <= soc_pkg::ACCESS;
						csr_we <= bus_req_i.we;
					end
				end
				// Write strobe is one cycle wide
				soc_pkg::ACCESS: begin
					state <= soc_pkg::DONE;
					csr_we <= 1'b0;
				end
				default: state <= soc_pkg::IDLE;
			endcase
		end
	end

	// Address and write data latched at the start
	always_ff @(posedge sys_clk) begin
		if (state == soc_pkg::IDLE) begin
			csr_a <= bus_req_i.adr[15:2];
			csr_dw <= bus_req_i.dat;
		end
	end

	// Read data captured on the way into DONE
	always_ff @(posedge sys_clk) begin
		if (state == soc_pkg::ACCESS)
			rdata <= csr_rdata_i;
	end

	assign csr_o = '{a: csr_a, we: csr_we, dw: csr_dw};
	assign bus_rsp_o = '{ack: (state == soc_pkg::DONE), dat: rdata};

endmodule

`default_nettype wire

/* verilog/sysctl.sv */
/*
 * System controller on the CSR bus
 * GPIO, one interval timer, interrupt pending and system ID
 * Reads are combinational so the bridge can sample them next cycle
 */
`timescale 1ns/100ps
`default_nettype none
`include "soc_macros.svh"

module sysctl (
	input logic sys_clk,
	input logic rst1,
	input soc_pkg::csr_req_t csr_i,
	output soc_pkg::word_t csr_rdata_o,
	input logic [`SOC_GPIO_IN_W-1:0] gpio_i,
	output logic [`SOC_GPIO_OUT_W-1:0] gpio_o,
	output logic [1:0] irq_o
);

	logic [`SOC_GPIO_IN_W-1:0] gpio_meta;
	logic [`SOC_GPIO_IN_W-1:0] gpio_sync;
	logic [`SOC_GPIO_IN_W-1:0] gpio_last;
	logic [`SOC_GPIO_OUT_W-1:0] gpio_out;
	logic [9:0] reg_idx;
	logic bank_hit;
	logic wr_en;
	logic tmr_en;
	logic tmr_ar;
	logic tmr_hit;
	soc_pkg::word_t tmr_cmp;
	soc_pkg::word_t tmr_cnt;
	logic [1:0] pending;
	logic [1:0] set_pend;
	logic [1:0] clr_pend;

	// Bank select and register index
	assign bank_hit = (csr_i.a[13:10] == `SOC_SYSCTL_BANK);
	assign reg_idx = csr_i.a[9:0];
	assign wr_en = bank_hit & csr_i.we;

	// Two-flop sync, plus one more stage for edge detect
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_i;
		gpio_sync <= gpio_meta;
		gpio_last <= gpio_sync;
	end

	// ------------------------------
	// Timer and output registers
	// ------------------------------
	assign tmr_hit = tmr_en & (tmr_cnt == tmr_cmp);

	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			gpio_out <= '0;
			tmr_en <= 1'b0;
			tmr_ar <= 1'b0;
			tmr_cmp <= '0;
			tmr_cnt <= '0;
		end else begin
			if (tmr_en) begin
				if (tmr_hit) begin
					tmr_cnt <= '0;
					// One-shot mode stops here
					if (!tmr_ar)
						tmr_en <= 1'b0;
				end else begin
					tmr_cnt <= tmr_cnt + 32'd1;
				end
			end
			// Bus writes override the timer update
			if (wr_en) begin
				case (reg_idx)
					10'd1: gpio_out <= csr_i.dw[`SOC_GPIO_OUT_W-1:0];
					10'd2: {tmr_ar, tmr_en} <= csr_i.dw[1:0];
					10'd3: tmr_cmp <= csr_i.dw;
					10'd4: tmr_cnt <= csr_i.dw;
					default: ;
				endcase
			end
		end
	end

	// Bit 0 gpio change, bit 1 timer
	assign set_pend = {tmr_hit, (gpio_sync != gpio_last)};
	assign clr_pend = (wr_en && reg_idx == 10'd5) ? csr_i.dw[1:0] : 2'b00;

	// Set wins over a write-1 clear in the same cycle
	always_ff @(posedge sys_clk) begin
		if (rst1)
			pending <= 2'b00;
		else
			pending <= (pending & ~clr_pend) | set_pend;
	end

	// Read mux, zero outside the bank
	always_comb begin
		csr_rdata_o = '0;
		if (bank_hit) begin
			case (reg_idx)
				10'd0: csr_rdata_o = soc_pkg::word_t'(gpio_sync);
				10'd1: csr_rdata_o = soc_pkg::word_t'(gpio_out);
				10'd2: csr_rdata_o = {30'd0, tmr_ar, tmr_en};
				10'd3: csr_rdata_o = tmr_cmp;
				10'd4: csr_rdata_o = tmr_cnt;
				10'd5: csr_rdata_o = {30'd0, pending};
				10'd6: csr_rdata_o = `SOC_SYSTEM_ID;
				default: csr_rdata_o = '0;
			endcase
		end
	end

	assign gpio_o = gpio_out;
	assign irq_o = pending;

endmodule

`default_nettype wire

/* verilog/soc_top.sv */
/*
 * System core without CPU
 * Instruction and data master ports face the testbench
 * RAM at 0x20000000, system controller behind the CSR bridge at 0x80000000
 */
`timescale 1ns/100ps
`default_nettype none
`include "soc_macros.svh"

module soc_top (
	input logic sys_clk,
	input logic rst1,
	input soc_pkg::bus_req_t ibus_req_i,
	input soc_pkg::bus_req_t dbus_req_i,
	output soc_pkg::bus_rsp_t ibus_rsp_o,
	output soc_pkg::bus_rsp_t dbus_rsp_o,
	input logic [`SOC_GPIO_IN_W-1:0] gpio_i,
	output logic [`SOC_GPIO_OUT_W-1:0] gpio_o,
	output logic [1:0] irq_o
);

	// Slave side of the arbiter
	soc_pkg::bus_req_t bram_req;
	soc_pkg::bus_rsp_t bram_rsp;
	soc_pkg::bus_req_t csr_bus_req;
	soc_pkg::bus_rsp_t csr_bus_rsp;

	// CSR bus
	soc_pkg::csr_req_t csr_req;
	soc_pkg::word_t csr_rdata;

	// ------------------------------
	// Bus switch
	// ------------------------------
	bus_arbiter bus_arbiter (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.ibus_req_i(ibus_req_i),
		.dbus_req_i(dbus_req_i),
		.ibus_rsp_o(ibus_rsp_o),
		.dbus_rsp_o(dbus_rsp_o),
		.bram_req_o(bram_req),
		.csr_req_o(csr_bus_req),
		.bram_rsp_i(bram_rsp),
		.csr_rsp_i(csr_bus_rsp)
	);

	bram bram (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.req_i(bram_req),
		.rsp_o(bram_rsp)
	);

	// ------------------------------
	// CSR side
	// ------------------------------
	csr_bridge csr_bridge (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.bus_req_i(csr_bus_req),
		.bus_rsp_o(csr_bus_rsp),
		.csr_o(csr_req),
		.csr_rdata_i(csr_rdata)
	);

	sysctl sysctl (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.csr_i(csr_req),
		.csr_rdata_o(csr_rdata),
		.gpio_i(gpio_i),
		.gpio_o(gpio_o),
		.irq_o(irq_o)
	);

endmodule

`default_nettype wire

/* verification/tb_clkgen.sv */
/*
 * Clock and reset source for the testbench
 * 4 ns sys_clk, rst1 high for the first 4 cycles
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
	output logic sys_clk,
	output logic rst1
);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		rst1 = 1'b1;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		rst1 = 1'b0;
	end

endmodule

`default_nettype wire

/* verification/soc_tb.sv */
/*
 * Testbench for the CPU-less system core
 * Acts as both bus masters, keeps a model of RAM and sysctl,
 * and stops at the first mismatch or timeout
 */
`timescale 1ns/100ps
`default_nettype none
`include "soc_macros.svh"

module soc_tb;

	localparam int ACK_TIMEOUT = 32;
	localparam int IRQ_TIMEOUT = 200;
	localparam int N_WORDS = 16;

	logic sys_clk;
	logic rst1;
	soc_pkg::bus_req_t ibus_req;
	soc_pkg::bus_req_t dbus_req;
	soc_pkg::bus_rsp_t ibus_rsp;
	soc_pkg::bus_rsp_t dbus_rsp;
	logic [`SOC_GPIO_IN_W-1:0] gpio_in;
	logic [`SOC_GPIO_OUT_W-1:0] gpio_out;
	logic [1:0] irq;

	// Reference model state
	soc_pkg::word_t ram_model [0:(1 << `SOC_BRAM_ADR_WIDTH) - 1];
	logic [`SOC_GPIO_IN_W-1:0] exp_gpio_in;
	logic [`SOC_GPIO_OUT_W-1:0] exp_gpio_out;
	logic [1:0] exp_ctrl;
	soc_pkg::word_t exp_cmp;
	logic [1:0] exp_pending;

	soc_pkg::addr_t ram_adr [N_WORDS];
	soc_pkg::addr_t adr_i;
	soc_pkg::addr_t adr_d;
	soc_pkg::word_t got_i;
	soc_pkg::word_t got_d;
	int tries;

	tb_clkgen clkgen (
		.sys_clk(sys_clk),
		.rst1(rst1)
	);

	soc_top uut (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.ibus_req_i(ibus_req),
		.dbus_req_i(dbus_req),
		.ibus_rsp_o(ibus_rsp),
		.dbus_rsp_o(dbus_rsp),
		.gpio_i(gpio_in),
		.gpio_o(gpio_out),
		.irq_o(irq)
	);

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic soc_pkg::word_t expected_read(input soc_pkg::addr_t adr);
		soc_pkg::csr_addr_t a;
		a = adr[15:2];
		case (adr[31:29])
			`SOC_REGION_BRAM: return ram_model[adr[`SOC_BRAM_ADR_WIDTH+1:2]];
			`SOC_REGION_CSR: begin
				// Foreign bank reads zero
				if (a[13:10] != `SOC_SYSCTL_BANK)
					return '0;
				case (a[9:0])
					10'd0: return soc_pkg::word_t'(exp_gpio_in);
					10'd1: return soc_pkg::word_t'(exp_gpio_out);
					10'd2: return {30'd0, exp_ctrl};
					10'd3: return exp_cmp;
					10'd5: return {30'd0, exp_pending};
					10'd6: return `SOC_SYSTEM_ID;
					default: return '0;
				endcase
			end
			// Unmapped, zero data
			default: return '0;
		endcase
	endfunction

	function automatic void model_write(input soc_pkg::addr_t adr, input soc_pkg::sel_t sel,
		input soc_pkg::word_t dat);
		soc_pkg::csr_addr_t a;
		a = adr[15:2];
		if (adr[31:29] == `SOC_REGION_BRAM) begin
			// Only selected lanes change
			for (int i = 0; i < 4; i++) begin
				if (sel[i])
					ram_model[adr[`SOC_BRAM_ADR_WIDTH+1:2]][8*i +: 8] = dat[8*i +: 8];
			end
		end else if (adr[31:29] == `SOC_REGION_CSR && a[13:10] == `SOC_SYSCTL_BANK) begin
			case (a[9:0])
				10'd1: exp_gpio_out = dat[`SOC_GPIO_OUT_W-1:0];
				10'd2: exp_ctrl = dat[1:0];
				10'd3: exp_cmp = dat;
				// Write 1 to clear
				10'd5: exp_pending = exp_pending & ~dat[1:0];
				default: ;
			endcase
		end
	endfunction

	function automatic soc_pkg::addr_t csr_adr(input logic [3:0] bank, input logic [9:0] idx);
		return {`SOC_REGION_CSR, 13'd0, bank, idx, 2'b00};
	endfunction

	// ------------------------------
	// Failure and compare tasks
	// ------------------------------
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopping on first failure");
	endtask

	task automatic check_word(input soc_pkg::word_t got, input soc_pkg::word_t exp,
		input string what);
		if (got !== exp)
			stop_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_irq(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp)
			stop_run($sformatf("ERROR at %0t: %s irq_o is %b, expected %b", $time, what, got,
				exp));
	endtask

	// ------------------------------
	// Master port cycles
	// ------------------------------
	// Called on a falling edge, returns on one
	task automatic dbus_cycle(input logic we, input soc_pkg::addr_t adr,
		input soc_pkg::sel_t sel, input soc_pkg::word_t dat, output soc_pkg::word_t rdata);
		int waited;
		waited = 0;
		dbus_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
		do begin
			@(negedge sys_clk);
			waited++;
			if (waited > ACK_TIMEOUT)
				stop_run($sformatf("No ack on the data port for address %h", adr));
		end while (dbus_rsp.ack !== 1'b1);
		rdata = dbus_rsp.dat;
		dbus_req = '0;
		// One idle cycle between requests
		@(negedge sys_clk);
	endtask

	task automatic ibus_read(input soc_pkg::addr_t adr, output soc_pkg::word_t rdata);
		int waited;
		waited = 0;
		ibus_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, sel: 4'hf, dat: '0};
		do begin
			@(negedge sys_clk);
			waited++;
			if (waited > ACK_TIMEOUT)
				stop_run($sformatf("No ack on the instruction port for address %h", adr));
		end while (ibus_rsp.ack !== 1'b1);
		rdata = ibus_rsp.dat;
		ibus_req = '0;
		@(negedge sys_clk);
	endtask

	task automatic write_word(input soc_pkg::addr_t adr, input soc_pkg::sel_t sel,
		input soc_pkg::word_t dat);
		soc_pkg::word_t unused;
		model_write(adr, sel, dat);
		dbus_cycle(1'b1, adr, sel, dat, unused);
	endtask

	task automatic read_and_check(input soc_pkg::addr_t adr, input string what);
		soc_pkg::word_t got;
		dbus_cycle(1'b0, adr, 4'hf, '0, got);
		check_word(got, expected_read(adr), what);
	endtask

	task automatic wait_irq(input int bit_idx, input string what);
		int waited;
		waited = 0;
		while (irq[bit_idx] !== 1'b1) begin
			@(negedge sys_clk);
			waited++;
			if (waited > IRQ_TIMEOUT)
				stop_run($sformatf("The %s interrupt never rose", what));
		end
	endtask

	// New nonzero pattern on the pins, so an edge is guaranteed
	task automatic change_gpio();
		gpio_in = gpio_in ^ `SOC_GPIO_IN_W'($urandom_range((1 << `SOC_GPIO_IN_W) - 1, 1));
		exp_gpio_in = gpio_in;
		exp_pending[0] = 1'b1;
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		ibus_req = '0;
		dbus_req = '0;
		gpio_in = '0;
		exp_gpio_in = '0;
		exp_gpio_out = '0;
		exp_ctrl = 2'b00;
		exp_cmp = '0;
		exp_pending = 2'b00;
		void'($urandom(32'h4bb0_dc63));

		tries = 0;
		do begin
			@(negedge sys_clk);
			tries++;
			if (tries > 20)
				stop_run("Reset never released");
		end while (rst1 !== 1'b0);

		// RAM fill, then partial-lane updates, then readback
		for (int i = 0; i < N_WORDS; i++) begin
			ram_adr[i] = {`SOC_REGION_BRAM, 17'd0, 10'($urandom_range(1023)), 2'b00};
			write_word(ram_adr[i], 4'hf, $urandom);
		end
		repeat (32)
			write_word(ram_adr[$urandom_range(N_WORDS - 1)], 4'($urandom_range(15)), $urandom);
		for (int i = 0; i < N_WORDS; i++)
			read_and_check(ram_adr[i], "RAM readback");

		// Both ports at once, data port wins first
		repeat (8) begin
			adr_i = ram_adr[$urandom_range(N_WORDS - 1)];
			adr_d = ram_adr[$urandom_range(N_WORDS - 1)];
			fork
				ibus_read(adr_i, got_i);
				dbus_cycle(1'b0, adr_d, 4'hf, '0, got_d);
			join
			check_word(got_i, expected_read(adr_i), "Instruction port read");
			check_word(got_d, expected_read(adr_d), "Data port read");
		end

		// CSR block
		read_and_check(csr_adr(`SOC_SYSCTL_BANK, 10'd6), "System ID");
		write_word(csr_adr(`SOC_SYSCTL_BANK, 10'd1), 4'hf, $urandom);
		check_word(soc_pkg::word_t'(gpio_out), soc_pkg::word_t'(exp_gpio_out), "gpio_o pins");
		read_and_check(csr_adr(`SOC_SYSCTL_BANK, 10'd1), "GPIO output register");
		read_and_check(csr_adr(4'h2, 10'd6), "Foreign bank");

		// Input pins show up after the synchronizer
		change_gpio();
		tries = 0;
		do begin
			dbus_cycle(1'b0, csr_adr(`SOC_SYSCTL_BANK, 10'd0), 4'hf, '0, got_d);
			tries++;
			if (tries > 10)
				stop_run("GPIO input never reached its register");
		end while (got_d !== expected_read(csr_adr(`SOC_SYSCTL_BANK, 10'd0)));
		check_irq(irq, exp_pending, "After GPIO input change");
		write_word(csr_adr(`SOC_SYSCTL_BANK, 10'd5), 4'hf, 32'd1);
		check_irq(irq, exp_pending, "After GPIO pending clear");

		// One-shot timer
		write_word(csr_adr(`SOC_SYSCTL_BANK, 10'd3), 4'hf, $urandom_range(12, 4));
		write_word(csr_adr(`SOC_SYSCTL_BANK, 10'd2), 4'hf, 32'd1);
		wait_irq(1, "timer");
		exp_pending[1] = 1'b1;
		// No autoreload, so enable drops on the hit
		exp_ctrl[0] = exp_ctrl[1];
		check_irq(irq, exp_pending, "Timer hit");
		read_and_check(csr_adr(`SOC_SYSCTL_BANK, 10'd2), "Timer control");
		read_and_check(csr_adr(`SOC_SYSCTL_BANK, 10'd5), "Pending register");
		write_word(csr_adr(`SOC_SYSCTL_BANK, 10'd5), 4'hf, 32'd2);
		check_irq(irq, exp_pending, "After timer pending clear");

		// GPIO edge interrupt
		change_gpio();
		wait_irq(0, "GPIO");
		check_irq(irq, exp_pending, "GPIO edge");
		write_word(csr_adr(`SOC_SYSCTL_BANK, 10'd5), 4'hf, 32'd1);
		check_irq(irq, exp_pending, "After GPIO edge clear");

		// Unmapped region, same low bits as a live RAM word
		adr_d = {3'b010, ram_adr[0][28:0]};
		read_and_check(adr_d, "Unmapped read");
		write_word(adr_d, 4'hf, ~expected_read(ram_adr[0]));
		read_and_check(ram_adr[0], "RAM after unmapped write");

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verilog
verilog/soc_pkg.sv
verilog/bus_arbiter.sv
verilog/bram.sv
verilog/csr_bridge.sv
verilog/sysctl.sv
verilog/soc_top.sv
verification/tb_clkgen.sv
verification/soc_tb.sv
